// File: verilog/decode_pkg.sv
package decode_pkg;

    // ****************************************
    // widths with a meaning
    // ****************************************
    typedef logic [31:0] word_t;      // data or address word
    typedef logic [4:0]  reg_addr_t;  // gpr number
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [11:0] alu_op_t;    // one-hot, add down to lui

    // ****************************************
    // encodings
    // ****************************************
    localparam opcode_t OP_SPECIAL = 6'b000000;  // r-type, decoded on funct
    localparam opcode_t OP_REGIMM  = 6'b000001;  // branch kind sits in rt
    localparam opcode_t OP_J       = 6'b000010;
    localparam opcode_t OP_JAL     = 6'b000011;
    localparam opcode_t OP_BEQ     = 6'b000100;
    localparam opcode_t OP_BNE     = 6'b000101;
    localparam opcode_t OP_BLEZ    = 6'b000110;
    localparam opcode_t OP_BGTZ    = 6'b000111;
    localparam opcode_t OP_ADDI    = 6'b001000;
    localparam opcode_t OP_ADDIU   = 6'b001001;
    localparam opcode_t OP_SLTI    = 6'b001010;
    localparam opcode_t OP_SLTIU   = 6'b001011;
    localparam opcode_t OP_ANDI    = 6'b001100;
    localparam opcode_t OP_ORI     = 6'b001101;
    localparam opcode_t OP_XORI    = 6'b001110;
    localparam opcode_t OP_LUI     = 6'b001111;
    localparam opcode_t OP_LB      = 6'b100000;
    localparam opcode_t OP_LH      = 6'b100001;
    localparam opcode_t OP_LW      = 6'b100011;
    localparam opcode_t OP_LBU     = 6'b100100;
    localparam opcode_t OP_LHU     = 6'b100101;
    localparam opcode_t OP_SB      = 6'b101000;
    localparam opcode_t OP_SH      = 6'b101001;
    localparam opcode_t OP_SW      = 6'b101011;

    localparam funct_t FN_SLL  = 6'b000000;
    localparam funct_t FN_SRL  = 6'b000010;
    localparam funct_t FN_SRA  = 6'b000011;
    localparam funct_t FN_SLLV = 6'b000100;
    localparam funct_t FN_SRLV = 6'b000110;
    localparam funct_t FN_SRAV = 6'b000111;
    localparam funct_t FN_JR   = 6'b001000;
    localparam funct_t FN_JALR = 6'b001001;
    localparam funct_t FN_ADD  = 6'b100000;
    localparam funct_t FN_ADDU = 6'b100001;
    localparam funct_t FN_SUB  = 6'b100010;
    localparam funct_t FN_SUBU = 6'b100011;
    localparam funct_t FN_AND  = 6'b100100;
    localparam funct_t FN_OR   = 6'b100101;
    localparam funct_t FN_XOR  = 6'b100110;
    localparam funct_t FN_NOR  = 6'b100111;
    localparam funct_t FN_SLT  = 6'b101010;
    localparam funct_t FN_SLTU = 6'b101011;

    localparam reg_addr_t RT_BLTZ   = 5'b00000;
    localparam reg_addr_t RT_BGEZ   = 5'b00001;
    localparam reg_addr_t RT_BLTZAL = 5'b10000;
    localparam reg_addr_t RT_BGEZAL = 5'b10001;

    localparam reg_addr_t LINK_REG    = 5'd31;
    localparam word_t     LINK_OFFSET = 32'd8;  // return lands past the delay slot
    localparam word_t     INST_STEP   = 32'd4;

    // ****************************************
    // buses between stages
    // ****************************************
    typedef struct packed {
        word_t inst;
        word_t pc;
    } if_id_bus_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } jbr_bus_t;

    typedef struct packed {
        logic load;
        logic store;
        logic l_sign;   // sign-extend byte/half loads
        logic ls_word;
        logic ls_byte;
        logic ls_half;
    } mem_ctrl_t;

    typedef struct packed {
        alu_op_t     alu_op;
        logic        link;
        logic        jr;
        logic        j_abs;        // j/jal, target from region bits
        logic        br_eq;
        logic        br_ne;
        logic        br_gez;
        logic        br_gtz;
        logic        br_lez;
        logic        br_ltz;
        logic        shift_sa;
        logic        imm_zero;
        logic        imm_sign;
        logic        uses_rt;      // rt read from the register file
        logic        check_overflow;
        mem_ctrl_t   mem_ctrl;
        logic        rf_wen;
        reg_addr_t   rf_wdest;
        logic        reserved;
        logic [4:0]  sa;
        logic [15:0] imm;
        logic [25:0] target;
        logic [15:0] offset;
    } decode_info_t;

    typedef struct packed {
        alu_op_t   alu_op;
        word_t     alu_operand1;
        word_t     alu_operand2;
        logic      check_overflow;
        mem_ctrl_t mem_ctrl;
        word_t     store_data;
        logic      rf_wen;
        reg_addr_t rf_wdest;
        logic      reserved;
        word_t     pc;
    } id_exe_bus_t;

endpackage

// File: verilog/instr_decoder.sv
module instr_decoder (
    input  decode_pkg::word_t        inst,
    output decode_pkg::reg_addr_t    rs,
    output decode_pkg::reg_addr_t    rt,
    output logic                     inst_jbr,
    output decode_pkg::decode_info_t info
);
    import decode_pkg::*;

    opcode_t    op;
    reg_addr_t  rd;
    logic [4:0] sa;
    funct_t     funct;
    logic       special, regimm, r_plain;
    logic       rs_zero, rt_zero, rd_zero;
    logic       i_add, i_addu, i_sub, i_subu, i_slt, i_sltu;
    logic       i_and, i_or, i_xor, i_nor;
    logic       i_sll, i_srl, i_sra, i_sllv, i_srlv, i_srav;
    logic       i_jr, i_jalr, i_j, i_jal;
    logic       i_addi, i_addiu, i_slti, i_sltiu, i_andi, i_ori, i_xori, i_lui;
    logic       i_beq, i_bne, i_blez, i_bgtz, i_bltz, i_bgez, i_bltzal, i_bgezal;
    logic       i_lw, i_lb, i_lbu, i_lh, i_lhu, i_sw, i_sb, i_sh;
    logic       r_alu, imm_alu, is_load, is_store, is_link;
    logic       wdest_rt, wdest_31, wdest_rd;

    assign op    = inst[31:26];
    assign rs    = inst[25:21];
    assign rt    = inst[20:16];
    assign rd    = inst[15:11];
    assign sa    = inst[10:6];
    assign funct = inst[5:0];

    assign special = (op == OP_SPECIAL);
    assign regimm  = (op == OP_REGIMM);
    assign rs_zero = (rs == 5'd0);
    assign rt_zero = (rt == 5'd0);
    assign rd_zero = (rd == 5'd0);
    assign r_plain = special & (sa == 5'd0);  // r-type with an empty sa field

    // ****************************************
    // instruction recognition
    // ****************************************
    assign i_add  = r_plain & (funct == FN_ADD);
    assign i_addu = r_plain & (funct == FN_ADDU);
    assign i_sub  = r_plain & (funct == FN_SUB);
    assign i_subu = r_plain & (funct == FN_SUBU);
    assign i_slt  = r_plain & (funct == FN_SLT);
    assign i_sltu = r_plain & (funct == FN_SLTU);
    assign i_and  = r_plain & (funct == FN_AND);
    assign i_or   = r_plain & (funct == FN_OR);
    assign i_xor  = r_plain & (funct == FN_XOR);
    assign i_nor  = r_plain & (funct == FN_NOR);
    assign i_sllv = r_plain & (funct == FN_SLLV);
    assign i_srlv = r_plain & (funct == FN_SRLV);
    assign i_srav = r_plain & (funct == FN_SRAV);
    assign i_sll  = special & rs_zero & (funct == FN_SLL);  // sa form, rs unused
    assign i_srl  = special & rs_zero & (funct == FN_SRL);
    assign i_sra  = special & rs_zero & (funct == FN_SRA);
    assign i_jr   = r_plain & rt_zero & rd_zero & (funct == FN_JR);
    assign i_jalr = r_plain & rt_zero & (funct == FN_JALR);

    assign i_addi  = (op == OP_ADDI);
    assign i_addiu = (op == OP_ADDIU);
    assign i_slti  = (op == OP_SLTI);
    assign i_sltiu = (op == OP_SLTIU);
    assign i_andi  = (op == OP_ANDI);
    assign i_ori   = (op == OP_ORI);
    assign i_xori  = (op == OP_XORI);
    assign i_lui   = (op == OP_LUI) & rs_zero;

    assign i_beq    = (op == OP_BEQ);
    assign i_bne    = (op == OP_BNE);
    assign i_blez   = (op == OP_BLEZ) & rt_zero;
    assign i_bgtz   = (op == OP_BGTZ) & rt_zero;
    assign i_bltz   = regimm & (rt == RT_BLTZ);
    assign i_bgez   = regimm & (rt == RT_BGEZ);
    assign i_bltzal = regimm & (rt == RT_BLTZAL);
    assign i_bgezal = regimm & (rt == RT_BGEZAL);
    assign i_j      = (op == OP_J);
    assign i_jal    = (op == OP_JAL);

    assign i_lw  = (op == OP_LW);
    assign i_lb  = (op == OP_LB);
    assign i_lbu = (op == OP_LBU);
    assign i_lh  = (op == OP_LH);
    assign i_lhu = (op == OP_LHU);
    assign i_sw  = (op == OP_SW);
    assign i_sb  = (op == OP_SB);
    assign i_sh  = (op == OP_SH);

    // ****************************************
    // classification
    // ****************************************
    assign r_alu = i_add | i_addu | i_sub | i_subu | i_slt | i_sltu | i_and | i_or
                 | i_xor | i_nor | i_sll | i_srl | i_sra | i_sllv | i_srlv | i_srav;
    assign imm_alu  = i_addi | i_addiu | i_slti | i_sltiu | i_andi | i_ori | i_xori | i_lui;
    assign is_load  = i_lw | i_lb | i_lbu | i_lh | i_lhu;
    assign is_store = i_sw | i_sb | i_sh;
    assign is_link  = i_jal | i_jalr | i_bltzal | i_bgezal;  // pc+8 into a gpr
    assign inst_jbr = i_j | i_jal | i_jr | i_jalr | i_beq | i_bne | i_blez | i_bgtz
                    | i_bltz | i_bgez | i_bltzal | i_bgezal;

    assign wdest_rt = imm_alu | is_load;
    assign wdest_31 = i_jal | i_bltzal | i_bgezal;
    assign wdest_rd = r_alu | i_jalr;

    always_comb begin
        info.alu_op = {i_add | i_addu | i_addi | i_addiu | is_load | is_store | is_link,
                       i_sub | i_subu,
                       i_slt | i_slti,
                       i_sltu | i_sltiu,
                       i_and | i_andi,
                       i_nor,
                       i_or | i_ori,
                       i_xor | i_xori,
                       i_sll | i_sllv,
                       i_srl | i_srlv,
                       i_sra | i_srav,
                       i_lui};
        info.link           = is_link;
        info.jr             = i_jr | i_jalr;
        info.j_abs          = i_j | i_jal;
        info.br_eq          = i_beq;
        info.br_ne          = i_bne;
        info.br_gez         = i_bgez | i_bgezal;
        info.br_gtz         = i_bgtz;
        info.br_lez         = i_blez;
        info.br_ltz         = i_bltz | i_bltzal;
        info.shift_sa       = i_sll | i_srl | i_sra;
        info.imm_zero       = i_andi | i_ori | i_xori | i_lui;
        info.imm_sign       = i_addi | i_addiu | i_slti | i_sltiu | is_load | is_store;
        info.uses_rt        = r_alu | i_beq | i_bne | is_store;
        info.check_overflow = i_add | i_addi | i_sub;
        info.mem_ctrl.load    = is_load;
        info.mem_ctrl.store   = is_store;
        info.mem_ctrl.l_sign  = i_lb | i_lh;
        info.mem_ctrl.ls_word = i_lw | i_sw;
        info.mem_ctrl.ls_byte = i_lb | i_lbu | i_sb;
        info.mem_ctrl.ls_half = i_lh | i_lhu | i_sh;
        info.rf_wen   = wdest_rt | wdest_31 | wdest_rd;
        // zero when nothing is written, keeps hazard compares clean downstream
        info.rf_wdest = wdest_rt ? rt : wdest_31 ? LINK_REG : wdest_rd ? rd : 5'd0;
        info.reserved = ~(r_alu | imm_alu | is_load | is_store | inst_jbr);
        info.sa     = sa;
        info.imm    = inst[15:0];
        info.target = inst[25:0];
        info.offset = inst[15:0];
    end

endmodule

// File: verilog/branch_unit.sv
module branch_unit (
    input  decode_pkg::word_t        pc,
    input  decode_pkg::word_t        rs_value,
    input  decode_pkg::word_t        rt_value,
    input  decode_pkg::decode_info_t info,
    input  logic                     id_over,
    output decode_pkg::jbr_bus_t     jbr_bus
);
    import decode_pkg::*;

    word_t bd_pc;
    word_t j_target;
    word_t br_target;
    logic  j_taken;
    logic  br_taken;
    logic  rs_eq_rt;
    logic  rs_ez;
    logic  rs_ltz;

    // ****************************************
    // targets
    // ****************************************
    assign bd_pc = pc + INST_STEP;  // delay-slot pc

    assign j_taken  = info.j_abs | info.jr;
    assign j_target = info.jr ? rs_value : {bd_pc[31:28], info.target, 2'b00};

    assign br_target = bd_pc + {{14{info.offset[15]}}, info.offset, 2'b00};

    // ****************************************
    // conditions
    // ****************************************
    assign rs_eq_rt = (rs_value == rt_value);
    assign rs_ez    = (rs_value == 32'd0);
    assign rs_ltz   = rs_value[31];  // sign bit

    assign br_taken = info.br_eq  & rs_eq_rt
                    | info.br_ne  & ~rs_eq_rt
                    | info.br_gez & ~rs_ltz
                    | info.br_gtz & ~rs_ltz & ~rs_ez
                    | info.br_lez & (rs_ltz | rs_ez)
                    | info.br_ltz & rs_ltz;

    // fetch may only redirect once id is done with it
    assign jbr_bus.taken  = (j_taken | br_taken) & id_over;
    assign jbr_bus.target = j_taken ? j_target : br_target;

endmodule

// File: verilog/stage_ctrl.sv
module stage_ctrl (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  id_valid,
    input  logic                  if_over,
    input  decode_pkg::reg_addr_t rs,
    input  decode_pkg::reg_addr_t rt,
    input  decode_pkg::reg_addr_t exe_wdest,
    input  decode_pkg::reg_addr_t mem_wdest,
    input  decode_pkg::reg_addr_t wb_wdest,
    input  logic                  inst_jbr,
    input  logic                  uses_rt,
    output logic                  rs_wait,
    output logic                  rt_wait,
    output logic                  id_over,
    output logic                  exe_valid
);
    import decode_pkg::*;

    // source still waiting on a later stage's write
    function automatic logic pending(input reg_addr_t src, input reg_addr_t d_exe,
                                     input reg_addr_t d_mem, input reg_addr_t d_wb);
        return (src != 5'd0) & ((src == d_exe) | (src == d_mem) | (src == d_wb));
    endfunction

    assign rs_wait = pending(rs, exe_wdest, mem_wdest, wb_wdest);
    assign rt_wait = uses_rt & pending(rt, exe_wdest, mem_wdest, wb_wdest);

    // a jump/branch must also see fetch finish, or the redirect is lost
    assign id_over = id_valid & ~rs_wait & ~rt_wait & (~inst_jbr | if_over);

    always_ff @(posedge clk) begin
        if (reset) begin
            exe_valid <= 1'b0;
        end else begin
            exe_valid <= id_over;  // bubble into exe when id stalls
        end
    end

endmodule

// File: verilog/exe_bundle.sv
module exe_bundle (
    input  logic                     clk,
    input  decode_pkg::word_t        pc,
    input  decode_pkg::word_t        rs_value,
    input  decode_pkg::word_t        rt_value,
    input  decode_pkg::decode_info_t info,
    input  logic                     id_over,
    output decode_pkg::id_exe_bus_t  id_exe_bus
);
    import decode_pkg::*;

    word_t       imm_zext;
    word_t       imm_sext;
    word_t       operand1;
    word_t       operand2;
    id_exe_bus_t next_bus;

    // ****************************************
    // operand selection
    // ****************************************
    assign imm_zext = {16'd0, info.imm};
    assign imm_sext = {{16{info.imm[15]}}, info.imm};

    // link computes pc + 8 in the alu
    assign operand1 = info.link     ? pc
                    : info.shift_sa ? {27'd0, info.sa}
                    : rs_value;

    assign operand2 = info.link     ? LINK_OFFSET
                    : info.imm_zero ? imm_zext
                    : info.imm_sign ? imm_sext
                    : rt_value;

    always_comb begin
        next_bus.alu_op         = info.alu_op;
        next_bus.alu_operand1   = operand1;
        next_bus.alu_operand2   = operand2;
        next_bus.check_overflow = info.check_overflow;
        next_bus.mem_ctrl       = info.mem_ctrl;
        next_bus.store_data     = rt_value;
        next_bus.rf_wen         = info.rf_wen;
        next_bus.rf_wdest       = info.rf_wdest;
        next_bus.reserved       = info.reserved;
        next_bus.pc             = pc;
    end

    // ****************************************
    // id/exe register
    // ****************************************
    always_ff @(posedge clk) begin
        if (id_over) begin
            id_exe_bus <= next_bus;  // holds while id stalls
        end
    end

endmodule

// File: verilog/decode_top.sv
module decode_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    id_valid,
    input  decode_pkg::if_id_bus_t  if_id_bus,
    input  decode_pkg::word_t       rs_value,
    input  decode_pkg::word_t       rt_value,
    input  logic                    if_over,
    input  decode_pkg::reg_addr_t   exe_wdest,
    input  decode_pkg::reg_addr_t   mem_wdest,
    input  decode_pkg::reg_addr_t   wb_wdest,
    output decode_pkg::reg_addr_t   rs,
    output decode_pkg::reg_addr_t   rt,
    output logic                    inst_jbr,
    output logic                    id_over,
    output logic                    rs_wait,
    output logic                    rt_wait,
    output decode_pkg::jbr_bus_t    jbr_bus,
    output decode_pkg::word_t       id_pc,
    output decode_pkg::id_exe_bus_t id_exe_bus,
    output logic                    exe_valid
);
    import decode_pkg::*;

    decode_info_t info;  // shared decode result

    assign id_pc = if_id_bus.pc;

    instr_decoder u_decoder (
        .inst     (if_id_bus.inst),
        .rs       (rs),
        .rt       (rt),
        .inst_jbr (inst_jbr),
        .info     (info)
    );

    branch_unit u_branch (
        .pc       (if_id_bus.pc),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .info     (info),
        .id_over  (id_over),
        .jbr_bus  (jbr_bus)
    );

    stage_ctrl u_ctrl (
        .clk       (clk),
        .reset     (reset),
        .id_valid  (id_valid),
        .if_over   (if_over),
        .rs        (rs),
        .rt        (rt),
        .exe_wdest (exe_wdest),
        .mem_wdest (mem_wdest),
        .wb_wdest  (wb_wdest),
        .inst_jbr  (inst_jbr),
        .uses_rt   (info.uses_rt),
        .rs_wait   (rs_wait),
        .rt_wait   (rt_wait),
        .id_over   (id_over),
        .exe_valid (exe_valid)
    );

    exe_bundle u_bundle (
        .clk        (clk),
        .pc         (if_id_bus.pc),
        .rs_value   (rs_value),
        .rt_value   (rt_value),
        .info       (info),
        .id_over    (id_over),
        .id_exe_bus (id_exe_bus)
    );

endmodule

// File: sim/decode_properties.sv
module decode_properties (
    input logic clk,
    input logic reset,
    input logic rs_wait,
    input logic rt_wait,
    input logic id_over,
    input logic exe_valid
);

    // ****************************************
    // stage control rules
    // ****************************************
    // nothing reaches exe right after reset
    exe_valid_after_reset: assert property (
        @(posedge clk) reset |=> !exe_valid
    ) else $error("exe_valid high after a reset cycle");

    // a waiting source blocks completion
    no_over_while_waiting: assert property (
        @(posedge clk) disable iff (reset) (rs_wait || rt_wait) |-> !id_over
    ) else $error("id_over high while a source waits");

endmodule

bind stage_ctrl decode_properties u_props (.*);

// File: sim/decode_tb.sv
module decode_tb;
    import decode_pkg::*;

    localparam int NUM_CYCLES = 3000;
    localparam int TIMEOUT    = 100;   // cycles allowed for any wait
    localparam int NUM_KINDS  = 48;    // 44 kept forms and 4 dropped ones

    // ****************************************
    // instruction tables indexed by kind
    // ****************************************
    localparam funct_t FN_TAB [16] = '{FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU,
        FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV};
    localparam opcode_t OP_TAB [16] = '{OP_LUI, OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
        OP_ANDI, OP_ORI, OP_XORI, OP_LW, OP_LB, OP_LBU, OP_LH, OP_LHU, OP_SW, OP_SB, OP_SH};
    // one-hot bit position with add at 11 and lui at 0
    localparam int ALU_BIT [24] = '{11, 11, 10, 10, 9, 8, 7, 5, 4, 6, 3, 2, 1, 3, 2, 1,
        0, 11, 11, 9, 8, 7, 5, 4};

    typedef struct packed {
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic        rs_wait;
        logic        rt_wait;
        logic        id_over;
        logic        jbr;
        jbr_bus_t    jbr_bus;
        id_exe_bus_t bus;
    } expect_t;

    logic        clk;
    logic        reset;
    logic        id_valid;
    logic        if_over;
    if_id_bus_t  if_id_bus;
    word_t       rs_value;
    word_t       rt_value;
    reg_addr_t   exe_wdest;
    reg_addr_t   mem_wdest;
    reg_addr_t   wb_wdest;
    reg_addr_t   rs;
    reg_addr_t   rt;
    logic        inst_jbr;
    logic        id_over;
    logic        rs_wait;
    logic        rt_wait;
    jbr_bus_t    jbr_bus;
    word_t       id_pc;
    id_exe_bus_t id_exe_bus;
    logic        exe_valid;

    int          kind;          // table index of the driven instruction
    logic [31:0] lfsr_state;
    int          errors;
    logic        checks_done;

    decode_top uut (.*);

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = 32'd0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // f holds rs, rt, rd, sa and imm in their usual places
    function automatic word_t make_inst(input int k, input logic [25:0] f);
        if (k < 16)
            return (k >= 10 && k <= 12) ? {OP_SPECIAL, 5'd0, f[20:6], FN_TAB[k]}
                                        : {OP_SPECIAL, f[25:11], 5'd0, FN_TAB[k]};
        if (k == 16) return {OP_LUI, 5'd0, f[20:0]};
        if (k < 32)  return {OP_TAB[k-16], f};
        case (k)
            32: return {OP_BEQ, f};
            33: return {OP_BNE, f};
            34: return {OP_REGIMM, f[25:21], RT_BGEZ, f[15:0]};
            35: return {OP_BGTZ, f[25:21], 5'd0, f[15:0]};
            36: return {OP_BLEZ, f[25:21], 5'd0, f[15:0]};
            37: return {OP_REGIMM, f[25:21], RT_BLTZ, f[15:0]};
            38: return {OP_REGIMM, f[25:21], RT_BGEZAL, f[15:0]};
            39: return {OP_REGIMM, f[25:21], RT_BLTZAL, f[15:0]};
            40: return {OP_J, f};
            41: return {OP_JAL, f};
            42: return {OP_SPECIAL, f[25:21], 15'd0, FN_JR};
            43: return {OP_SPECIAL, f[25:21], 5'd0, f[15:11], 5'd0, FN_JALR};
            44: return {OP_SPECIAL, f[25:16], 10'd0, 6'b011000};  // mult
            45: return {OP_SPECIAL, f[25:6], 6'b001100};          // syscall
            46: return {6'b100010, f};                            // lwl
            default: return {6'b010000, 5'b10000, 15'd0, 6'b011000};  // eret
        endcase
    endfunction

    function automatic expect_t ref_decode(input int k, input if_id_bus_t ib,
                                           input word_t rsv, input word_t rtv,
                                           input reg_addr_t de, input reg_addr_t dm,
                                           input reg_addr_t dw, input logic valid,
                                           input logic fetch_done);
        expect_t     e;
        reg_addr_t   s1;
        reg_addr_t   s2;
        logic        link;
        logic        uses_rt;
        logic        cond;
        word_t       bd;
        logic [15:0] imm;
        s1      = ib.inst[25:21];
        s2      = ib.inst[20:16];
        imm     = ib.inst[15:0];
        bd      = ib.pc + 32'd4;
        link    = (k == 38 || k == 39 || k == 41 || k == 43);
        uses_rt = (k < 16 || k == 32 || k == 33 || (k >= 29 && k <= 31));
        e = '0;
        e.rs      = s1;
        e.rt      = s2;
        e.rs_wait = (s1 != 5'd0) && (s1 == de || s1 == dm || s1 == dw);
        e.rt_wait = uses_rt && (s2 != 5'd0) && (s2 == de || s2 == dm || s2 == dw);
        e.jbr     = (k >= 32 && k <= 43);
        e.id_over = valid && !e.rs_wait && !e.rt_wait && (!e.jbr || fetch_done);

        // alu and operands
        if (k < 24) e.bus.alu_op[ALU_BIT[k]] = 1'b1;
        if ((k >= 24 && k <= 31) || link) e.bus.alu_op[11] = 1'b1;
        e.bus.alu_operand1 = link ? ib.pc : (k >= 10 && k <= 12) ? {27'd0, ib.inst[10:6]} : rsv;
        if (link)
            e.bus.alu_operand2 = 32'd8;
        else if (k == 16 || (k >= 21 && k <= 23))
            e.bus.alu_operand2 = {16'd0, imm};
        else if (k >= 17 && k <= 31)
            e.bus.alu_operand2 = {{16{imm[15]}}, imm};
        else
            e.bus.alu_operand2 = rtv;
        e.bus.check_overflow = (k == 0 || k == 2 || k == 17);
        e.bus.mem_ctrl = {k >= 24 && k <= 28, k >= 29 && k <= 31, k == 25 || k == 27,
                          k == 24 || k == 29, k == 25 || k == 26 || k == 30,
                          k == 27 || k == 28 || k == 31};
        e.bus.store_data = rtv;
        if (k < 16 || k == 43) begin
            e.bus.rf_wen   = 1'b1;
            e.bus.rf_wdest = ib.inst[15:11];
        end else if (k >= 16 && k <= 28) begin
            e.bus.rf_wen   = 1'b1;
            e.bus.rf_wdest = s2;
        end else if (link) begin
            e.bus.rf_wen   = 1'b1;
            e.bus.rf_wdest = 5'd31;
        end
        e.bus.reserved = (k >= 44);
        e.bus.pc       = ib.pc;

        // jumps and branches
        case (k)
            32:      cond = (rsv == rtv);
            33:      cond = (rsv != rtv);
            34, 38:  cond = !rsv[31];
            35:      cond = !rsv[31] && rsv != 32'd0;
            36:      cond = rsv[31] || rsv == 32'd0;
            37, 39:  cond = rsv[31];
            40, 41, 42, 43: cond = 1'b1;
            default: cond = 1'b0;
        endcase
        e.jbr_bus.taken = cond && e.id_over;
        if (k == 40 || k == 41)
            e.jbr_bus.target = {bd[31:28], ib.inst[25:0], 2'b00};
        else if (k == 42 || k == 43)
            e.jbr_bus.target = rsv;
        else
            e.jbr_bus.target = bd + {{14{imm[15]}}, imm, 2'b00};
        return e;
    endfunction

    task automatic check_value(input logic [255:0] got, input logic [255:0] exp,
                               input string what);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s (kind %0d): got %0h, expected %0h",
                     $time, what, kind, got, exp);
        end
    endtask

    // pending destination now and then aimed at a source register
    function automatic reg_addr_t pick_dest(input reg_addr_t a, input reg_addr_t b);
        logic [31:0] s;
        s = rand_bits(3);
        if (s == 0) return a;
        if (s == 1) return b;
        return reg_addr_t'(rand_bits(5));
    endfunction

    task automatic drive_random();
        logic [31:0] r;
        int          k;
        word_t       inst;
        word_t       rsv;
        word_t       rtv;
        k    = int'(rand_bits(6) % NUM_KINDS);
        r    = rand_bits(26);
        inst = make_inst(k, r[25:0]);
        r    = rand_bits(30);
        kind           <= k;
        if_id_bus.inst <= inst;
        if_id_bus.pc   <= {r[29:0], 2'b00};
        r   = rand_bits(2);
        rsv = (r == 1) ? 32'd0 : rand_bits(32);
        rtv = (r == 0) ? rsv : rand_bits(32);  // equal operands for beq/bne
        rs_value  <= rsv;
        rt_value  <= rtv;
        exe_wdest <= pick_dest(inst[25:21], inst[20:16]);
        mem_wdest <= pick_dest(inst[25:21], inst[20:16]);
        wb_wdest  <= pick_dest(inst[25:21], inst[20:16]);
        id_valid  <= (rand_bits(3) != 0);
        if_over   <= (rand_bits(2) != 0);
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ****************************************
    // stimulus and end of run
    // ****************************************
    initial begin
        int n;
        lfsr_state  = 32'h88b1aeba;
        errors      = 0;
        checks_done = 1'b0;
        reset       = 1'b1;
        id_valid    = 1'b0;
        if_over     = 1'b0;
        if_id_bus   = '0;
        rs_value    = '0;
        rt_value    = '0;
        exe_wdest   = '0;
        mem_wdest   = '0;
        wb_wdest    = '0;
        kind        = 0;
        repeat (5) @(posedge clk);
        for (int i = 0; i < NUM_CYCLES + 2; i++) begin
            reset <= 1'b0;
            drive_random();
            @(posedge clk);
        end
        n = 0;
        while (!checks_done && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (!checks_done) begin
            $display("comparison process did not finish in time");
            errors++;
        end
        $display("checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // ****************************************
    // comparison at the falling edge
    // ****************************************
    initial begin
        int          n;
        expect_t     e;
        expect_t     prev;
        id_exe_bus_t held;
        logic        loaded;
        n      = 0;
        prev   = '0;
        held   = '0;
        loaded = 1'b0;
        while (reset !== 1'b0 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (reset !== 1'b0) begin
            $display("reset was never released");
            errors++;
        end else begin
            for (int i = 0; i < NUM_CYCLES; i++) begin
                e = ref_decode(kind, if_id_bus, rs_value, rt_value, exe_wdest,
                               mem_wdest, wb_wdest, id_valid, if_over);
                check_value(256'(rs), 256'(e.rs), "rs");
                check_value(256'(rt), 256'(e.rt), "rt");
                check_value(256'(rs_wait), 256'(e.rs_wait), "rs_wait");
                check_value(256'(rt_wait), 256'(e.rt_wait), "rt_wait");
                check_value(256'(inst_jbr), 256'(e.jbr), "inst_jbr");
                check_value(256'(id_over), 256'(e.id_over), "id_over");
                check_value(256'(jbr_bus.taken), 256'(e.jbr_bus.taken), "jbr taken");
                if (e.jbr)
                    check_value(256'(jbr_bus.target), 256'(e.jbr_bus.target), "jbr target");
                check_value(256'(id_pc), 256'(if_id_bus.pc), "id_pc");
                // registered side lags one cycle
                check_value(256'(exe_valid), 256'(prev.id_over), "exe_valid");
                if (prev.id_over) begin
                    held   = prev.bus;
                    loaded = 1'b1;
                end
                if (loaded)
                    check_value(256'(id_exe_bus), 256'(held), "id_exe_bus");
                prev = e;
                @(negedge clk);
            end
        end
        checks_done = 1'b1;
    end

endmodule

// File: mips_decode.f
verilog/decode_pkg.sv
verilog/instr_decoder.sv
verilog/branch_unit.sv
verilog/stage_ctrl.sv
verilog/exe_bundle.sv
verilog/decode_top.sv
sim/decode_properties.sv
sim/decode_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module decode_tb \
    -f mips_decode.f -o decode_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/decode_sim > sim.log 2>&1
grep -qF '*** TEST FAILED ***' sim.log && { echo "simulation failed"; exit 1; }
grep -qF '*** TEST PASSED ***' sim.log \
    && echo "simulation passed" \
    || { echo "simulation ended without a result"; exit 1; }
